//--- mips_pkg.sv
package mips_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_W    = 5;
    localparam int PC_W     = 32;
    localparam int IM_DEPTH = 64;   // Words
    localparam int DM_DEPTH = 64;   // Words

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25
    } funct_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // Control bits carried down the pipeline
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    halt;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- hazard_if.sv
`timescale 1ns/1ps

interface hazard_if;
    import mips_pkg::*;

    logic [REG_W-1:0] if_id_rs;
    logic [REG_W-1:0] if_id_rt;
    logic [REG_W-1:0] id_ex_rs;
    logic [REG_W-1:0] id_ex_rt;
    logic             id_ex_mem_read;
    logic [REG_W-1:0] ex_mem_rd;
    logic             ex_mem_reg_write;
    logic [REG_W-1:0] mem_wb_rd;
    logic             mem_wb_reg_write;
    logic             branch_taken;
    fwd_sel_e         fwd_a;
    fwd_sel_e         fwd_b;
    logic             stall;
    logic             flush;

    modport hazard (
        input  if_id_rs, if_id_rt, id_ex_rs, id_ex_rt, id_ex_mem_read,
        input  ex_mem_rd, ex_mem_reg_write, mem_wb_rd, mem_wb_reg_write, branch_taken,
        output fwd_a, fwd_b, stall, flush
    );
    modport fetch   (input stall, flush);
    modport decode  (output if_id_rs, if_id_rt, input stall, flush);
    modport execute (output id_ex_rs, id_ex_rt, id_ex_mem_read,
                     input if_id_rs, if_id_rt, fwd_a, fwd_b, flush);
    modport memory  (output ex_mem_rd, ex_mem_reg_write, mem_wb_rd, mem_wb_reg_write,
                     output branch_taken);

endinterface

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IM_DEPTH = mips_pkg::IM_DEPTH
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_run,
    input  logic                        i_freeze,
    input  logic                        i_im_we,
    input  logic [$clog2(IM_DEPTH)-1:0] i_im_addr,
    input  logic [mips_pkg::DATA_W-1:0] i_im_data,
    input  logic [mips_pkg::PC_W-1:0]   i_branch_target,
    hazard_if.fetch                     hz,
    output logic [mips_pkg::PC_W-1:0]   o_pc,
    output logic [mips_pkg::DATA_W-1:0] o_if_id_instr,
    output logic [mips_pkg::PC_W-1:0]   o_if_id_pc_plus4
);
    import mips_pkg::*;

    localparam int IM_AW = $clog2(IM_DEPTH);

    logic [DATA_W-1:0] imem [IM_DEPTH];
    logic [PC_W-1:0]   pc;
    logic [PC_W-1:0]   pc_plus4;

    assign pc_plus4 = pc + PC_W'(4);
    assign o_pc     = pc;

    always_ff @(posedge i_clock) begin
        if (i_im_we) begin
            imem[i_im_addr] <= i_im_data;   // Debug load port
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc               <= '0;
            o_if_id_instr    <= '0;
            o_if_id_pc_plus4 <= '0;
        end else if (hz.flush) begin
            pc            <= i_branch_target;
            o_if_id_instr <= '0;
        end else if (!hz.stall) begin
            if (i_run && !i_freeze) begin
                pc               <= pc_plus4;
                o_if_id_instr    <= imem[pc[IM_AW+1:2]];
                o_if_id_pc_plus4 <= pc_plus4;
            end else begin
                o_if_id_instr <= '0;        // NOP while idle or halted
            end
        end
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic [mips_pkg::DATA_W-1:0] i_instr,
    input  logic [mips_pkg::PC_W-1:0]   i_pc_plus4,
    input  logic                        i_wb_we,
    input  logic [mips_pkg::REG_W-1:0]  i_wb_rd,
    input  logic [mips_pkg::DATA_W-1:0] i_wb_data,
    input  logic [mips_pkg::REG_W-1:0]  i_rb_addr,
    output logic [mips_pkg::DATA_W-1:0] o_rb_data,
    output logic                        o_halt_seen,
    hazard_if.decode                    hz,
    output mips_pkg::ctrl_t             o_id_ex_ctrl,
    output logic [mips_pkg::DATA_W-1:0] o_id_ex_a,
    output logic [mips_pkg::DATA_W-1:0] o_id_ex_b,
    output logic [mips_pkg::DATA_W-1:0] o_id_ex_imm,
    output logic [mips_pkg::REG_W-1:0]  o_id_ex_rd,
    output logic [mips_pkg::PC_W-1:0]   o_id_ex_pc_plus4
);
    import mips_pkg::*;

    logic [DATA_W-1:0] regs [32];
    opcode_e           opcode;
    funct_e            funct;
    logic [REG_W-1:0]  rs;
    logic [REG_W-1:0]  rt;
    logic [REG_W-1:0]  dest;
    ctrl_t             ctrl;
    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    logic              halt_q;

    assign opcode      = opcode_e'(i_instr[31:26]);
    assign funct       = funct_e'(i_instr[5:0]);
    assign rs          = i_instr[25:21];
    assign rt          = i_instr[20:16];
    assign hz.if_id_rs = rs;
    assign hz.if_id_rt = rt;
    assign o_rb_data   = regs[i_rb_addr];
    assign o_halt_seen = halt_q || ctrl.halt;

    always_comb begin
        ctrl = '0;
        dest = rt;
        case (opcode)
            OP_RTYPE: begin
                dest           = i_instr[15:11];
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    default: ctrl.reg_write = 1'b0;   // All-zero word lands here
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    // Write-first bypass
    always_comb begin
        rd_a = (i_wb_we && i_wb_rd == rs && rs != '0) ? i_wb_data : regs[rs];
        rd_b = (i_wb_we && i_wb_rd == rt && rt != '0) ? i_wb_data : regs[rt];
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_we && i_wb_rd != '0) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Sticky once HALT goes down, cleared when a branch kills it
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_q <= 1'b0;
        end else if (hz.flush) begin
            halt_q <= 1'b0;
        end else if (ctrl.halt) begin
            halt_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex_ctrl <= '0;
        end else begin
            o_id_ex_ctrl <= (hz.stall || hz.flush) ? '0 : ctrl;
        end
    end

    always_ff @(posedge i_clock) begin
        o_id_ex_a        <= rd_a;
        o_id_ex_b        <= rd_b;
        o_id_ex_imm      <= {{(DATA_W-16){i_instr[15]}}, i_instr[15:0]};
        o_id_ex_rd       <= dest;
        o_id_ex_pc_plus4 <= i_pc_plus4;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  mips_pkg::ctrl_t             i_id_ex_ctrl,
    input  logic [mips_pkg::DATA_W-1:0] i_id_ex_a,
    input  logic [mips_pkg::DATA_W-1:0] i_id_ex_b,
    input  logic [mips_pkg::DATA_W-1:0] i_id_ex_imm,
    input  logic [mips_pkg::REG_W-1:0]  i_id_ex_rd,
    input  logic [mips_pkg::PC_W-1:0]   i_id_ex_pc_plus4,
    input  logic [mips_pkg::DATA_W-1:0] i_mem_fwd_data,
    input  logic [mips_pkg::DATA_W-1:0] i_wb_fwd_data,
    hazard_if.execute                   hz,
    output mips_pkg::ctrl_t             o_ex_mem_ctrl,
    output logic [mips_pkg::DATA_W-1:0] o_ex_mem_alu,
    output logic [mips_pkg::DATA_W-1:0] o_ex_mem_store_data,
    output logic [mips_pkg::REG_W-1:0]  o_ex_mem_rd,
    output logic                        o_ex_mem_zero,
    output logic [mips_pkg::PC_W-1:0]   o_ex_mem_target
);
    import mips_pkg::*;

    logic [REG_W-1:0]  rs_q;
    logic [REG_W-1:0]  rt_q;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] fwd_b_data;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;

    function automatic logic [DATA_W-1:0] fwd_mux(input fwd_sel_e sel,
                                                  input logic [DATA_W-1:0] reg_val);
        case (sel)
            FWD_MEM: return i_mem_fwd_data;
            FWD_WB:  return i_wb_fwd_data;
            default: return reg_val;
        endcase
    endfunction

    assign hz.id_ex_rs       = rs_q;
    assign hz.id_ex_rt       = rt_q;
    assign hz.id_ex_mem_read = i_id_ex_ctrl.mem_read;

    always_comb begin
        op_a       = fwd_mux(hz.fwd_a, i_id_ex_a);
        fwd_b_data = fwd_mux(hz.fwd_b, i_id_ex_b);
        op_b       = i_id_ex_ctrl.alu_src ? i_id_ex_imm : fwd_b_data;
        case (i_id_ex_ctrl.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            default: alu_res = op_a | op_b;
        endcase
    end

    // Source indices of the instruction now in EX
    always_ff @(posedge i_clock) begin
        rs_q <= hz.if_id_rs;
        rt_q <= hz.if_id_rt;
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem_ctrl <= '0;
        end else begin
            o_ex_mem_ctrl <= hz.flush ? '0 : i_id_ex_ctrl;
        end
    end

    always_ff @(posedge i_clock) begin
        o_ex_mem_alu        <= alu_res;
        o_ex_mem_store_data <= fwd_b_data;
        o_ex_mem_rd         <= i_id_ex_rd;
        o_ex_mem_zero       <= (alu_res == '0);
        o_ex_mem_target     <= i_id_ex_pc_plus4 + (i_id_ex_imm << 2);
    end

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int DM_DEPTH = mips_pkg::DM_DEPTH
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  mips_pkg::ctrl_t             i_ex_mem_ctrl,
    input  logic [mips_pkg::DATA_W-1:0] i_ex_mem_alu,
    input  logic [mips_pkg::DATA_W-1:0] i_ex_mem_store_data,
    input  logic [mips_pkg::REG_W-1:0]  i_ex_mem_rd,
    input  logic                        i_ex_mem_zero,
    input  logic [mips_pkg::PC_W-1:0]   i_ex_mem_target,
    hazard_if.memory                    hz,
    output logic [mips_pkg::PC_W-1:0]   o_branch_target,
    output logic [mips_pkg::DATA_W-1:0] o_mem_fwd_data,
    output logic                        o_wb_we,
    output logic [mips_pkg::REG_W-1:0]  o_wb_rd,
    output logic [mips_pkg::DATA_W-1:0] o_wb_data,
    output logic                        o_hlt
);
    import mips_pkg::*;

    localparam int DM_AW = $clog2(DM_DEPTH);

    logic [DATA_W-1:0] dmem [DM_DEPTH];
    logic [DM_AW-1:0]  dm_idx;
    logic              wb_mem_to_reg;
    logic              wb_halt;
    logic [DATA_W-1:0] wb_alu;
    logic [DATA_W-1:0] wb_load;

    assign dm_idx              = i_ex_mem_alu[DM_AW+1:2];
    assign o_branch_target     = i_ex_mem_target;
    assign o_mem_fwd_data      = i_ex_mem_alu;
    assign hz.branch_taken     = i_ex_mem_ctrl.branch && i_ex_mem_zero;
    assign hz.ex_mem_rd        = i_ex_mem_rd;
    assign hz.ex_mem_reg_write = i_ex_mem_ctrl.reg_write;
    assign hz.mem_wb_rd        = o_wb_rd;
    assign hz.mem_wb_reg_write = o_wb_we;
    assign o_wb_data           = wb_mem_to_reg ? wb_load : wb_alu;

    always_ff @(posedge i_clock) begin
        if (i_ex_mem_ctrl.mem_write) begin
            dmem[dm_idx] <= i_ex_mem_store_data;
        end
        wb_alu  <= i_ex_mem_alu;
        wb_load <= dmem[dm_idx];
        o_wb_rd <= i_ex_mem_rd;
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_we       <= 1'b0;
            wb_mem_to_reg <= 1'b0;
            wb_halt       <= 1'b0;
            o_hlt         <= 1'b0;
        end else begin
            o_wb_we       <= i_ex_mem_ctrl.reg_write;
            wb_mem_to_reg <= i_ex_mem_ctrl.mem_read;
            wb_halt       <= i_ex_mem_ctrl.halt;
            o_hlt         <= o_hlt || wb_halt;   // Sticky until reset
        end
    end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    hazard_if.hazard hz
);
    import mips_pkg::*;

    logic load_use;

    // MEM entry is younger, so it wins over WB
    function automatic fwd_sel_e pick_src(input logic [REG_W-1:0] src);
        if (hz.ex_mem_reg_write && hz.ex_mem_rd != '0 && hz.ex_mem_rd == src) begin
            return FWD_MEM;
        end
        if (hz.mem_wb_reg_write && hz.mem_wb_rd != '0 && hz.mem_wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        hz.fwd_a = pick_src(hz.id_ex_rs);
        hz.fwd_b = pick_src(hz.id_ex_rt);
    end

    assign load_use = hz.id_ex_mem_read && hz.id_ex_rt != '0 &&
                      (hz.id_ex_rt == hz.if_id_rs || hz.id_ex_rt == hz.if_id_rt);

    assign hz.flush = hz.branch_taken;
    assign hz.stall = load_use && !hz.branch_taken;   // Flush has priority

endmodule

//--- mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline #(
    parameter int IM_DEPTH = mips_pkg::IM_DEPTH,
    parameter int DM_DEPTH = mips_pkg::DM_DEPTH
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_run,
    input  logic                        i_im_we,
    input  logic [$clog2(IM_DEPTH)-1:0] i_im_addr,
    input  logic [mips_pkg::DATA_W-1:0] i_im_data,
    input  logic [mips_pkg::REG_W-1:0]  i_rb_addr,
    output logic [mips_pkg::DATA_W-1:0] o_rb_data,
    output logic [mips_pkg::PC_W-1:0]   o_pc_value,
    output logic                        o_hlt
);
    import mips_pkg::*;

    logic [DATA_W-1:0] if_id_instr;
    logic [PC_W-1:0]   if_id_pc_plus4;
    logic              halt_seen;
    ctrl_t             id_ex_ctrl;
    logic [DATA_W-1:0] id_ex_a;
    logic [DATA_W-1:0] id_ex_b;
    logic [DATA_W-1:0] id_ex_imm;
    logic [REG_W-1:0]  id_ex_rd;
    logic [PC_W-1:0]   id_ex_pc_plus4;
    ctrl_t             ex_mem_ctrl;
    logic [DATA_W-1:0] ex_mem_alu;
    logic [DATA_W-1:0] ex_mem_store_data;
    logic [REG_W-1:0]  ex_mem_rd;
    logic              ex_mem_zero;
    logic [PC_W-1:0]   ex_mem_target;
    logic [PC_W-1:0]   branch_target;
    logic [DATA_W-1:0] mem_fwd_data;
    logic              wb_we;
    logic [REG_W-1:0]  wb_rd;
    logic [DATA_W-1:0] wb_data;

    hazard_if u_hz ();

    fetch_stage #(.IM_DEPTH(IM_DEPTH)) u_fetch (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_run(i_run), .i_freeze(halt_seen),
        .i_im_we(i_im_we), .i_im_addr(i_im_addr), .i_im_data(i_im_data),
        .i_branch_target(branch_target), .hz(u_hz.fetch), .o_pc(o_pc_value),
        .o_if_id_instr(if_id_instr), .o_if_id_pc_plus4(if_id_pc_plus4)
    );

    decode_stage u_decode (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_instr(if_id_instr),
        .i_pc_plus4(if_id_pc_plus4), .i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
        .i_rb_addr(i_rb_addr), .o_rb_data(o_rb_data), .o_halt_seen(halt_seen),
        .hz(u_hz.decode), .o_id_ex_ctrl(id_ex_ctrl), .o_id_ex_a(id_ex_a),
        .o_id_ex_b(id_ex_b), .o_id_ex_imm(id_ex_imm), .o_id_ex_rd(id_ex_rd),
        .o_id_ex_pc_plus4(id_ex_pc_plus4)
    );

    execute_stage u_execute (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_id_ex_ctrl(id_ex_ctrl),
        .i_id_ex_a(id_ex_a), .i_id_ex_b(id_ex_b), .i_id_ex_imm(id_ex_imm),
        .i_id_ex_rd(id_ex_rd), .i_id_ex_pc_plus4(id_ex_pc_plus4),
        .i_mem_fwd_data(mem_fwd_data), .i_wb_fwd_data(wb_data), .hz(u_hz.execute),
        .o_ex_mem_ctrl(ex_mem_ctrl), .o_ex_mem_alu(ex_mem_alu),
        .o_ex_mem_store_data(ex_mem_store_data), .o_ex_mem_rd(ex_mem_rd),
        .o_ex_mem_zero(ex_mem_zero), .o_ex_mem_target(ex_mem_target)
    );

    memory_stage #(.DM_DEPTH(DM_DEPTH)) u_memory (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_ex_mem_ctrl(ex_mem_ctrl),
        .i_ex_mem_alu(ex_mem_alu), .i_ex_mem_store_data(ex_mem_store_data),
        .i_ex_mem_rd(ex_mem_rd), .i_ex_mem_zero(ex_mem_zero),
        .i_ex_mem_target(ex_mem_target), .hz(u_hz.memory),
        .o_branch_target(branch_target), .o_mem_fwd_data(mem_fwd_data),
        .o_wb_we(wb_we), .o_wb_rd(wb_rd), .o_wb_data(wb_data), .o_hlt(o_hlt)
    );

    hazard_unit u_hazard (
        .hz(u_hz.hazard)
    );

endmodule

//--- mips_pipeline_sva.sv
`timescale 1ns/1ps

module mips_pipeline_sva (
    input logic                      i_clock,
    input logic                      i_rst_n,
    input logic                      i_hlt,
    input logic [mips_pkg::PC_W-1:0] i_pc_value
);
    int unsigned reset_errs = 0;
    int unsigned sticky_errs = 0;
    int unsigned pc_errs = 0;
    int unsigned err_count;

    assign err_count = reset_errs + sticky_errs + pc_errs;

    a_hlt_clear_after_reset: assert property (@(posedge i_clock) $rose(i_rst_n) |-> !i_hlt)
        else begin
            $error("o_hlt set in the first cycle after reset");
            reset_errs++;
        end

    // Sticky until reset
    a_hlt_sticky: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                                   i_hlt |=> i_hlt)
        else begin
            $error("o_hlt fell while out of reset");
            sticky_errs++;
        end

    a_pc_frozen: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                                  i_hlt |=> $stable(i_pc_value))
        else begin
            $error("o_pc_value moved while halted");
            pc_errs++;
        end

endmodule

bind mips_pipeline mips_pipeline_sva u_sva (
    .i_clock(i_clock),
    .i_rst_n(i_rst_n),
    .i_hlt(o_hlt),
    .i_pc_value(o_pc_value)
);

//--- tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline;
    import mips_pkg::*;

    localparam int IM_AW       = $clog2(IM_DEPTH);
    localparam int HLT_TIMEOUT = 2000;
    localparam int HOLD_CYCLES = 20;

    logic              clock;
    logic              rst_n;
    logic              run;
    logic              im_we;
    logic [IM_AW-1:0]  im_addr;
    logic [DATA_W-1:0] im_data;
    logic [REG_W-1:0]  rb_addr;
    logic [DATA_W-1:0] rb_data;
    logic [PC_W-1:0]   pc_value;
    logic              hlt;

    logic [DATA_W-1:0] prog [$];
    logic [DATA_W-1:0] model_regs [32];
    logic [DATA_W-1:0] model_dmem [DM_DEPTH];

    mips_pipeline #(.IM_DEPTH(IM_DEPTH), .DM_DEPTH(DM_DEPTH)) u_dut (
        .i_clock(clock), .i_rst_n(rst_n), .i_run(run), .i_im_we(im_we),
        .i_im_addr(im_addr), .i_im_data(im_data), .i_rb_addr(rb_addr),
        .o_rb_data(rb_data), .o_pc_value(pc_value), .o_hlt(hlt)
    );

    always #5 clock = ~clock;

    always @(negedge clock) begin
        if (u_dut.u_sva.err_count != 0) begin
            $display("A concurrent assertion on halt or PC behavior failed");
            $display("Verification failed");
            $fatal(1);
        end
    end

    function automatic logic [DATA_W-1:0] enc_r(funct_e fn, logic [4:0] rd,
                                                logic [4:0] rs, logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [DATA_W-1:0] enc_i(opcode_e op, logic [4:0] rt,
                                                logic [4:0] rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [DATA_W-1:0] sext16(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic string reg_group(int idx);
        if (idx == 0) return "r0_zero";
        if (idx <= 6) return "alu_chain";
        if (idx <= 10) return "load_use";
        if (idx <= 18) return "branch";
        return "untouched";
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        logic [15:0] off;
        imm_a = 16'($urandom);
        imm_b = 16'($urandom);
        off   = 16'(($urandom % 8) * 4);         // Word aligned
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, imm_a));
        prog.push_back(enc_r(FN_ADDU, 5'd2, 5'd1, 5'd1));   // Both from MEM
        prog.push_back(enc_r(FN_SUBU, 5'd3, 5'd2, 5'd1));   // MEM and WB
        prog.push_back(enc_r(FN_AND, 5'd4, 5'd3, 5'd2));
        prog.push_back(enc_r(FN_OR, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_i(OP_ADDI, 5'd6, 5'd5, imm_b));
        prog.push_back(enc_i(OP_ADDI, 5'd10, 5'd0, 16'd64));
        prog.push_back(enc_i(OP_SW, 5'd6, 5'd10, off));
        prog.push_back(enc_i(OP_LW, 5'd7, 5'd10, off));
        prog.push_back(enc_r(FN_ADDU, 5'd8, 5'd7, 5'd6));   // Load-use
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd8, 16'd5));  // Write to r0 is dropped
        prog.push_back(enc_r(FN_ADDU, 5'd9, 5'd0, 5'd8));
        prog.push_back(enc_i(OP_ADDI, 5'd11, 5'd0, 16'd7));
        prog.push_back(enc_i(OP_ADDI, 5'd12, 5'd0, 16'd7));
        prog.push_back(enc_i(OP_BEQ, 5'd12, 5'd11, 16'd3)); // Taken
        prog.push_back(enc_i(OP_ADDI, 5'd13, 5'd0, 16'd1));
        prog.push_back(enc_i(OP_ADDI, 5'd14, 5'd0, 16'd2));
        prog.push_back(enc_i(OP_ADDI, 5'd15, 5'd0, 16'd3));
        prog.push_back(enc_i(OP_ADDI, 5'd16, 5'd0, 16'd4));
        prog.push_back(enc_i(OP_BEQ, 5'd16, 5'd11, 16'd2)); // Not taken
        prog.push_back(enc_i(OP_ADDI, 5'd17, 5'd16, 16'd10));
        prog.push_back(enc_i(OP_ADDI, 5'd18, 5'd17, 16'd1));
        prog.push_back({OP_HALT, 26'd0});
    endtask

    // One instruction per step, no pipeline
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        int          idx;
        int          steps;
        logic        done;
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        while (!done && steps < 1000) begin
            idx = int'(pc >> 2);
            w   = (idx < prog.size()) ? prog[idx] : '0;
            a   = model_regs[w[25:21]];
            b   = model_regs[w[20:16]];
            imm = sext16(w[15:0]);
            pc  = pc + 32'd4;
            steps++;
            case (w[31:26])
                OP_RTYPE: begin
                    case (w[5:0])
                        FN_ADDU: model_regs[w[15:11]] = a + b;
                        FN_SUBU: model_regs[w[15:11]] = a - b;
                        FN_AND:  model_regs[w[15:11]] = a & b;
                        FN_OR:   model_regs[w[15:11]] = a | b;
                        default: ;
                    endcase
                end
                OP_ADDI: model_regs[w[20:16]] = a + imm;
                OP_LW:   model_regs[w[20:16]] = model_dmem[(a + imm) >> 2];
                OP_SW:   model_dmem[(a + imm) >> 2] = b;
                OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + (imm << 2);
                    end
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            model_regs[0] = '0;
        end
        check_value("model_reaches_halt", 32'd1, 32'(done));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clock);
            im_we   <= 1'b1;
            im_addr <= IM_AW'(i);
            im_data <= prog[i];
        end
        @(posedge clock);
        im_we <= 1'b0;
    endtask

    initial begin
        int waited;
        void'($urandom(32880));
        clock   = 1'b0;
        rst_n   = 1'b0;
        run     = 1'b0;
        im_we   = 1'b0;
        im_addr = '0;
        im_data = '0;
        rb_addr = '0;
        build_program();
        run_model();

        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_value("reset_state o_hlt", 32'd0, 32'(hlt));
        check_value("reset_state o_pc_value", 32'd0, pc_value);

        load_program();
        @(posedge clock);
        run <= 1'b1;

        waited = 0;
        while (!hlt && waited < HLT_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!hlt) begin
            $display("Timeout: o_hlt did not rise within %0d cycles", HLT_TIMEOUT);
            $display("Verification failed");
            $fatal(1);
        end

        // PC hold is watched by the bind module
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clock);
            check_value("halt_hold o_hlt", 32'd1, 32'(hlt));
        end

        for (int i = 0; i < 32; i++) begin
            @(posedge clock);
            rb_addr <= REG_W'(i);
            @(negedge clock);
            check_value($sformatf("%s r%0d", reg_group(i), i), model_regs[i], rb_data);
        end

        if (u_dut.u_sva.err_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Concurrent assertions failed %0d times", u_dut.u_sva.err_count);
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

//--- vlog.f
mips_pkg.sv
hazard_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
mips_pipeline.sv
mips_pipeline_sva.sv
tb_mips_pipeline.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mips_pipeline -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mips_pipeline +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
exit 1
